/* src/isa_pkg.sv */
package isa_pkg;

    localparam int xlen       = 64;  // integer register width
    localparam int instr_w    = 32;  // no compressed forms
    localparam int reg_addr_w = 5;   // x0..x31

    // major opcodes, instruction bits 6:0
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [2:0] f3_addi  = 3'b000;
    localparam logic [2:0] f3_dword = 3'b011;  // ld and sd, 64 bit access

    // mret is one fixed word, no fields to pick apart
    localparam logic [instr_w-1:0] mret_word = 32'h3020_0073;

    // U format, lui
    typedef struct packed {
        logic [19:0]           imm;     // imm[31:12]
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    // I and S formats share this layout
    // the immediate lives in different fields for each
    typedef struct packed {
        logic [6:0]            funct7;  // imm[11:5] for both I and S
        logic [reg_addr_w-1:0] rs2;     // imm[4:0] for I
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;      // imm[4:0] for S
        logic [6:0]            opcode;
    } is_fmt_t;

    // same word, two readings
    typedef union packed {
        u_fmt_t  u_view;
        is_fmt_t is_view;
    } instr_t;

    typedef enum logic [2:0] {
        op_nop,      // bubble
        op_lui,
        op_addi,
        op_ld,
        op_sd,
        op_mret,
        op_illegal   // runs as a nop in execute
    } op_t;

endpackage

/* src/soc_pkg.sv */
package soc_pkg;

    // width of the memory mapped bus, data and address
    localparam int bus_data_w = 64;

    // instruction ram, also where the core starts after reset
    localparam logic [bus_data_w-1:0] ram_base = 64'h0000_0000_0000_1000;

    // key device, read only
    localparam logic [bus_data_w-1:0] key_base = 64'h0000_0000_0001_0000;

    // output device, write only
    localparam logic [bus_data_w-1:0] art_base = 64'h0000_0000_0002_0000;

    // fixed interrupt handler entry
    localparam logic [bus_data_w-1:0] trap_base = 64'h0000_0000_0000_0100;

endpackage

/* src/decode_exec_if.sv */
`timescale 1ns/1ps

// one decoded instruction, decode -> execute
// no handshake, valid low means bubble
interface decode_exec_if;

    logic                          valid;
    isa_pkg::op_t                  op;
    logic [isa_pkg::reg_addr_w-1:0] rd;
    logic [isa_pkg::reg_addr_w-1:0] rs1;
    logic [isa_pkg::reg_addr_w-1:0] rs2;
    logic [isa_pkg::xlen-1:0]      imm;   // already sign extended
    logic [isa_pkg::xlen-1:0]      pc;    // pc of this instruction

    modport producer (
        output valid,
        output op,
        output rd,
        output rs1,
        output rs2,
        output imm,
        output pc
    );

    modport consumer (
        input valid,
        input op,
        input rd,
        input rs1,
        input rs2,
        input imm,
        input pc
    );

endinterface

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
    parameter logic [isa_pkg::xlen-1:0] reset_pc = 64'h1000
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [isa_pkg::instr_w-1:0] instruction,  // answered combinationally on pc
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [isa_pkg::xlen-1:0]    redirect_pc,
    output logic [isa_pkg::xlen-1:0]    pc,
    output logic [isa_pkg::instr_w-1:0] ir,
    output logic [isa_pkg::xlen-1:0]    ir_pc,
    output logic                        ir_valid,
    output logic                        heartbeat
);

    logic [isa_pkg::xlen-1:0] pc_next;

    // redirect wins over stall, stall wins over +4
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;  // hold while execute finishes an ld
        end else begin
            pc_next = pc + 64'd4;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc        <= reset_pc;
            ir_valid  <= 1'b0;
            heartbeat <= 1'b0;
        end else begin
            pc        <= pc_next;
            heartbeat <= ~heartbeat;  // sign of life
            if (redirect) begin
                ir_valid <= 1'b0;  // word fetched this cycle is on the wrong path
            end else if (!stall) begin
                ir_valid <= 1'b1;
            end
        end
    end

    // latched word and its pc, meaningful only with ir_valid
    always_ff @(posedge clk) begin
        if (!stall) begin
            ir    <= instruction;
            ir_pc <= pc;
        end
    end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [isa_pkg::instr_w-1:0] ir,
    input  logic [isa_pkg::xlen-1:0]    ir_pc,
    input  logic                        ir_valid,
    input  logic                        stall,
    input  logic                        redirect,
    decode_exec_if.producer             dx
);

    isa_pkg::instr_t          word;
    isa_pkg::op_t             dec_op;
    logic [isa_pkg::xlen-1:0] dec_imm;
    logic [isa_pkg::xlen-1:0] imm_u;
    logic [isa_pkg::xlen-1:0] imm_i;
    logic [isa_pkg::xlen-1:0] imm_s;

    assign word = ir;

    // U view: imm[31:12], low 12 bits zero, sign from bit 31
    assign imm_u = {{(isa_pkg::xlen-32){word.u_view.imm[19]}}, word.u_view.imm, 12'b0};

    // I view: funct7 and rs2 fields form imm[11:0]
    assign imm_i = {{(isa_pkg::xlen-12){word.is_view.funct7[6]}},
                    word.is_view.funct7, word.is_view.rs2};

    // S view: low five bits sit where rd would be
    assign imm_s = {{(isa_pkg::xlen-12){word.is_view.funct7[6]}},
                    word.is_view.funct7, word.is_view.rd};

    always_comb begin
        dec_op  = isa_pkg::op_illegal;
        dec_imm = '0;
        unique case (word.u_view.opcode)
            isa_pkg::opc_lui: begin
                dec_op  = isa_pkg::op_lui;
                dec_imm = imm_u;
            end
            isa_pkg::opc_op_imm: begin
                dec_imm = imm_i;
                if (word.is_view.funct3 == isa_pkg::f3_addi) dec_op = isa_pkg::op_addi;
            end
            isa_pkg::opc_load: begin
                dec_imm = imm_i;
                if (word.is_view.funct3 == isa_pkg::f3_dword) dec_op = isa_pkg::op_ld;  // ld only
            end
            isa_pkg::opc_store: begin
                dec_imm = imm_s;
                if (word.is_view.funct3 == isa_pkg::f3_dword) dec_op = isa_pkg::op_sd;  // sd only
            end
            isa_pkg::opc_system: begin
                // whole word match, no other csr ops
                if (ir == isa_pkg::mret_word) dec_op = isa_pkg::op_mret;
            end
            default: begin
                dec_op = isa_pkg::op_illegal;
            end
        endcase
        if (!ir_valid) dec_op = isa_pkg::op_nop;  // bubbles carry a nop
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            dx.valid <= 1'b0;
        end else if (redirect) begin
            dx.valid <= 1'b0;  // flush, younger than the redirecting instr
        end else if (!stall) begin
            dx.valid <= ir_valid;
        end
    end

    // payload, held with valid under stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            dx.op  <= dec_op;
            dx.rd  <= word.is_view.rd;
            dx.rs1 <= word.is_view.rs1;
            dx.rs2 <= word.is_view.rs2;
            dx.imm <= dec_imm;
            dx.pc  <= ir_pc;
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           we,
    input  logic [isa_pkg::reg_addr_w-1:0] waddr,
    input  logic [isa_pkg::xlen-1:0]       wdata,
    input  logic [isa_pkg::reg_addr_w-1:0] raddr_a,
    input  logic [isa_pkg::reg_addr_w-1:0] raddr_b,
    output logic [isa_pkg::xlen-1:0]       rdata_a,
    output logic [isa_pkg::xlen-1:0]       rdata_b
);

    logic [isa_pkg::xlen-1:0] regs [1:31];  // x0 has no storage

    // write port, ignored while reset is held
    always_ff @(posedge clk) begin
        if (reset && we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 reads zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage #(
    parameter logic [isa_pkg::xlen-1:0] trap_vector = 64'h100
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           irq,          // level
    input  logic [soc_pkg::bus_data_w-1:0] bus_read_data,
    decode_exec_if.consumer                dx,
    output logic                           stall,
    output logic                           redirect,
    output logic [isa_pkg::xlen-1:0]       redirect_pc,
    output logic                           irq_ack,
    output logic [soc_pkg::bus_data_w-1:0] bus_address,
    output logic [soc_pkg::bus_data_w-1:0] bus_write_data,
    output logic                           bus_write_enable,
    output logic                           bus_read_enable
);

    logic                     pending;    // inside handler until mret
    logic [isa_pkg::xlen-1:0] mepc;
    logic                     load_step;  // 1 = ld waiting for read data
    logic                     take_irq;
    logic                     perform;
    logic [isa_pkg::xlen-1:0] rs1_val;
    logic [isa_pkg::xlen-1:0] rs2_val;
    logic [isa_pkg::xlen-1:0] eff_addr;
    logic                     rf_we;
    logic [isa_pkg::xlen-1:0] rf_wdata;

    reg_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .we      (rf_we),
        .waddr   (dx.rd),
        .wdata   (rf_wdata),
        .raddr_a (dx.rs1),
        .raddr_b (dx.rs2),
        .rdata_a (rs1_val),
        .rdata_b (rs2_val)
    );

    // never break an ld between its read and its writeback
    assign take_irq = irq && !pending && dx.valid && !load_step;
    assign perform  = dx.valid && !take_irq;  // interrupted instr reruns after mret
    assign eff_addr = rs1_val + dx.imm;       // addi result and ld/sd address

    always_comb begin
        rf_we    = 1'b0;
        rf_wdata = dx.imm;
        case (dx.op)
            isa_pkg::op_lui: rf_we = perform;
            isa_pkg::op_addi: begin
                rf_we    = perform;
                rf_wdata = eff_addr;
            end
            isa_pkg::op_ld: begin
                rf_we    = perform && load_step;  // second step only
                rf_wdata = bus_read_data;
            end
            default: rf_we = 1'b0;  // nop, sd, mret, illegal
        endcase
    end

    // first ld step holds fetch and decode for one cycle
    assign stall = perform && (dx.op == isa_pkg::op_ld) && !load_step;

    assign irq_ack     = take_irq;
    assign redirect    = take_irq || (perform && (dx.op == isa_pkg::op_mret));
    assign redirect_pc = take_irq ? trap_vector : mepc;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pending          <= 1'b0;
            load_step        <= 1'b0;
            bus_read_enable  <= 1'b0;
            bus_write_enable <= 1'b0;
        end else begin
            bus_read_enable  <= stall;  // one pulse per ld
            bus_write_enable <= perform && (dx.op == isa_pkg::op_sd);
            load_step        <= stall;
            if (take_irq) begin
                pending <= 1'b1;
            end else if (perform && (dx.op == isa_pkg::op_mret)) begin
                pending <= 1'b0;  // back in the interrupted code
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_irq) mepc <= dx.pc;  // pc of the instr not performed
        if (stall || (perform && (dx.op == isa_pkg::op_sd))) begin
            bus_address    <= eff_addr;
            bus_write_data <= rs2_val;  // don't care on reads
        end
    end

endmodule

/* src/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
    parameter logic [isa_pkg::xlen-1:0] reset_pc    = soc_pkg::ram_base,
    parameter logic [isa_pkg::xlen-1:0] trap_vector = soc_pkg::trap_base
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [isa_pkg::instr_w-1:0]    instruction,
    input  logic                           irq,
    input  logic [soc_pkg::bus_data_w-1:0] bus_read_data,
    output logic [isa_pkg::xlen-1:0]       pc,
    output logic                           heartbeat,
    output logic                           irq_ack,
    output logic [soc_pkg::bus_data_w-1:0] bus_address,
    output logic [soc_pkg::bus_data_w-1:0] bus_write_data,
    output logic                           bus_write_enable,
    output logic                           bus_read_enable
);

    logic [isa_pkg::instr_w-1:0] ir;
    logic [isa_pkg::xlen-1:0]    ir_pc;
    logic                        ir_valid;
    logic                        stall;        // from execute, ld first step
    logic                        redirect;     // from execute, irq or mret
    logic [isa_pkg::xlen-1:0]    redirect_pc;

    decode_exec_if dx_bus ();

    fetch_stage #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .ir          (ir),
        .ir_pc       (ir_pc),
        .ir_valid    (ir_valid),
        .heartbeat   (heartbeat)
    );

    decode_stage u_decode (
        .clk      (clk),
        .reset    (reset),
        .ir       (ir),
        .ir_pc    (ir_pc),
        .ir_valid (ir_valid),
        .stall    (stall),
        .redirect (redirect),
        .dx       (dx_bus.producer)
    );

    execute_stage #(
        .trap_vector (trap_vector)
    ) u_execute (
        .clk              (clk),
        .reset            (reset),
        .irq              (irq),
        .bus_read_data    (bus_read_data),
        .dx               (dx_bus.consumer),
        .stall            (stall),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .irq_ack          (irq_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable)
    );

endmodule

/* dv/rv_core_sva.sv */
`timescale 1ns/1ps

// bus strobe and interrupt rules, bound into execute_stage
module rv_core_sva (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic irq_ack,
    input logic pending,
    input logic bus_read_enable,
    input logic bus_write_enable
);

    // a cycle is either a read or a write, never both
    a_no_read_write: assert property (@(posedge clk) disable iff (!reset)
        !(bus_read_enable && bus_write_enable))
        else $error("read and write enable high together");

    a_read_pulse: assert property (@(posedge clk) disable iff (!reset)
        bus_read_enable |=> !bus_read_enable)  // one pulse per ld
        else $error("read enable longer than one cycle");

    a_write_pulse: assert property (@(posedge clk) disable iff (!reset)
        bus_write_enable |=> !bus_write_enable)
        else $error("write enable longer than one cycle");

    // ack opens the handler, pending then blocks any nested ack
    a_ack_sets_pending: assert property (@(posedge clk) disable iff (!reset)
        irq_ack |=> pending)
        else $error("irq_ack did not set the pending flag");

    a_stall_single: assert property (@(posedge clk) disable iff (!reset)
        stall |=> !stall)  // ld adds one cycle only
        else $error("stall longer than one cycle");

endmodule

bind execute_stage rv_core_sva u_sva (
    .clk              (clk),
    .reset            (reset),
    .stall            (stall),
    .irq_ack          (irq_ack),
    .pending          (pending),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable)
);

/* dv/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    typedef struct {
        int prog_lo;   // first word in prog[]
        int prog_n;
        int irq_cyc;   // edge after reset release, -1 none
        int exp_lo;    // first expected write
        int exp_n;
        int reads;     // expected read pulses
        int acks;      // expected irq_ack pulses
        int max_cyc;
    } row_t;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic        irq;
    logic [63:0] bus_read_data;
    logic [63:0] pc;
    logic        heartbeat;
    logic        irq_ack;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;

    isa_pkg::instr_t prog [24];
    isa_pkg::instr_t imem [16];     // ram_base window
    isa_pkg::instr_t handler [4];   // trap_base window
    isa_pkg::instr_t nop_word;
    logic [63:0]     exp_addr [8];
    logic [63:0]     exp_data [8];
    bit              exp_key [8];   // data is the key value
    row_t            rows [4];
    logic [63:0]     wr_addr [$];
    logic [63:0]     wr_data [$];
    logic [63:0]     key;
    logic [31:0]     lfsr_state = 32'ha7cd;
    logic [63:0]     ram_off;
    logic [63:0]     trap_off;
    int              reads;
    int              acks;
    int              errors = 0;
    int              cycles = 0;
    int              limit = 0;
    int              cyc;
    bit              collecting = 0;

    rv_core_top uut (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .irq              (irq),
        .bus_read_data    (bus_read_data),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .irq_ack          (irq_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic isa_pkg::instr_t enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        isa_pkg::instr_t w;
        w.u_view.imm    = imm;
        w.u_view.rd     = rd;
        w.u_view.opcode = isa_pkg::opc_lui;
        return w;
    endfunction

    // addi and ld, I format
    function automatic isa_pkg::instr_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        isa_pkg::instr_t w;
        w.is_view.funct7 = imm[11:5];
        w.is_view.rs2    = imm[4:0];
        w.is_view.rs1    = rs1;
        w.is_view.funct3 = f3;
        w.is_view.rd     = rd;
        w.is_view.opcode = opc;
        return w;
    endfunction

    function automatic isa_pkg::instr_t enc_sd(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        isa_pkg::instr_t w;
        w.is_view.funct7 = imm[11:5];
        w.is_view.rs2    = rs2;
        w.is_view.rs1    = rs1;
        w.is_view.funct3 = isa_pkg::f3_dword;
        w.is_view.rd     = imm[4:0];  // S split immediate
        w.is_view.opcode = isa_pkg::opc_store;
        return w;
    endfunction

    // galois, x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_key();
        for (int i = 0; i < 64; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per key bit
            key = {key[62:0], lfsr_state[0]};
        end
    endtask

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %h exp %h", $time, msg, got, exp);
        end
    endtask

    // instruction memory, combinational on pc
    always_comb begin
        ram_off  = pc - soc_pkg::ram_base;
        trap_off = pc - soc_pkg::trap_base;
        if (ram_off < 64'd64) instruction = imem[ram_off[5:2]];
        else if (trap_off < 64'd16) instruction = handler[trap_off[3:2]];
        else instruction = nop_word;
    end

    // sample strobes away from the driving edge
    always @(negedge clk) begin
        if (reset && collecting) begin
            if (bus_write_enable) begin
                wr_addr.push_back(bus_address);
                wr_data.push_back(bus_write_data);
            end
            if (bus_read_enable) reads++;
            if (irq_ack) acks++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run exceeded %0d cycles waiting for bus writes", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic apply_reset();
        logic hb;
        @(posedge clk);
        #2 reset = 1'b0;
        repeat (4) @(posedge clk);
        #2 reset = 1'b1;
        check_val(pc, soc_pkg::ram_base, "pc after reset");
        check_val(64'(bus_read_enable | bus_write_enable), 64'd0, "strobe after reset");
        check_val(64'(irq_ack), 64'd0, "irq_ack after reset");
        @(negedge clk);
        hb = heartbeat;
        @(negedge clk);
        check_val(64'(heartbeat), 64'(!hb), "heartbeat toggle");
    endtask

    // one clock, irq and key device driven 2 ns after the edge
    task automatic step_cycle(input int r);
        @(posedge clk);
        #2;
        cyc++;
        if (cyc == rows[r].irq_cyc) irq = 1'b1;
        if (irq && acks > 0 && wr_data.size() >= 2) irq = 1'b0;  // marker seen
        if (bus_read_enable) begin
            check_val(bus_address, soc_pkg::key_base, "read address");
            bus_read_data = key;
        end else begin
            bus_read_data = '0;
        end
    endtask

    initial begin
        reset         = 1'b0;
        irq           = 1'b0;
        bus_read_data = '0;
        key           = '0;
        nop_word      = enc_i(isa_pkg::opc_op_imm, isa_pkg::f3_addi, 5'd0, 5'd0, 12'h000);

        // lui, addi negative, sd
        prog[0] = enc_lui(5'd1, 20'h12345);
        prog[1] = enc_i(isa_pkg::opc_op_imm, isa_pkg::f3_addi, 5'd1, 5'd1, 12'hff0);
        prog[2] = enc_lui(5'd2, 20'h00020);
        prog[3] = enc_sd(5'd1, 5'd2, 12'h000);
        // ld key then echo
        prog[4] = enc_lui(5'd3, 20'h00010);
        prog[5] = enc_i(isa_pkg::opc_load, isa_pkg::f3_dword, 5'd5, 5'd3, 12'h000);
        prog[6] = enc_lui(5'd2, 20'h00020);
        prog[7] = enc_sd(5'd5, 5'd2, 12'h000);
        // x0 discard
        prog[8]  = enc_lui(5'd0, 20'h00055);
        prog[9]  = enc_lui(5'd2, 20'h00020);
        prog[10] = enc_sd(5'd0, 5'd2, 12'h000);
        // sd run, irq lands on the second sd
        prog[11] = enc_lui(5'd2, 20'h00020);
        for (int i = 0; i < 4; i++) begin
            prog[12 + 2 * i] = enc_lui(5'd4, 20'(i + 1));
            prog[13 + 2 * i] = enc_sd(5'd4, 5'd2, 12'(8 * i));
        end
        handler[0] = enc_lui(5'd7, 20'habcde);
        handler[1] = enc_sd(5'd7, 5'd2, 12'h020);
        handler[2] = isa_pkg::instr_t'(isa_pkg::mret_word);
        handler[3] = nop_word;

        exp_addr[0] = soc_pkg::art_base;
        exp_data[0] = 64'h0000_0000_1234_4ff0;  // 0x12345000 - 16
        exp_addr[1] = soc_pkg::art_base;
        exp_data[1] = '0;
        exp_key[1]  = 1'b1;
        exp_addr[2] = soc_pkg::art_base;
        exp_data[2] = '0;
        exp_addr[3] = soc_pkg::art_base;
        exp_data[3] = 64'h1000;
        exp_addr[4] = soc_pkg::art_base + 64'd32;
        exp_data[4] = 64'hffff_ffff_abcd_e000;  // marker, lui sign extends
        for (int i = 1; i < 4; i++) begin
            exp_addr[4 + i] = soc_pkg::art_base + 64'(8 * i);
            exp_data[4 + i] = 64'(4096 * (i + 1));
        end

        rows[0] = '{0, 4, -1, 0, 1, 0, 0, 20};
        rows[1] = '{4, 4, -1, 1, 1, 1, 0, 20};
        rows[2] = '{8, 3, -1, 2, 1, 0, 0, 20};
        rows[3] = '{11, 9, 6, 3, 5, 0, 1, 40};
        limit = 20;
        foreach (rows[r]) limit += rows[r].max_cyc + 12;

        foreach (rows[r]) begin
            for (int i = 0; i < 16; i++) begin
                imem[i] = (i < rows[r].prog_n) ? prog[rows[r].prog_lo + i] : nop_word;
            end
            next_key();
            wr_addr.delete();
            wr_data.delete();
            reads = 0;
            acks  = 0;
            cyc   = 0;
            apply_reset();
            cyc = 1;  // heartbeat check used one edge
            collecting = 1'b1;
            while (wr_data.size() < rows[r].exp_n) step_cycle(r);
            repeat (4) step_cycle(r);  // catch extra writes
            collecting = 1'b0;
            irq = 1'b0;
            check_val(64'(wr_data.size()), 64'(rows[r].exp_n), $sformatf("row %0d writes", r));
            for (int i = 0; i < wr_data.size() && i < rows[r].exp_n; i++) begin
                check_val(wr_addr[i], exp_addr[rows[r].exp_lo + i],
                          $sformatf("row %0d write %0d address", r, i));
                check_val(wr_data[i], exp_key[rows[r].exp_lo + i] ? key
                          : exp_data[rows[r].exp_lo + i],
                          $sformatf("row %0d write %0d data", r, i));
            end
            check_val(64'(reads), 64'(rows[r].reads), $sformatf("row %0d read pulses", r));
            check_val(64'(acks), 64'(rows[r].acks), $sformatf("row %0d irq_ack pulses", r));
        end

        $display("errors: %0d mismatches", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
src/isa_pkg.sv
src/soc_pkg.sv
src/decode_exec_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/rv_core_top.sv
dv/rv_core_sva.sv
dv/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rv core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_rv_core -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# result decided by the log only
if grep -qx "TEST OK" sim.log; then
    exit 0
fi
exit 1
